/* tb.f */
src/oq_pkg.sv
src/oq_regs_pkg.sv
src/output_queues_regs.sv
src/oq_dispatch.sv
src/oq_fifo.sv
src/output_queues.sv
test/oq_checker.sv
test/tb_output_queues.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_output_queues
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_output_queues.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_output_queues;
   import oq_pkg::*;
   import oq_regs_pkg::*;

   localparam int DATA_WIDTH  = 32;
   localparam int ADDR_WIDTH  = 32;
   localparam int WORD_WIDTH  = 64;
   localparam int DEPTH_LOG2  = 3;
   localparam int RAND_ROUNDS = 3;
   localparam int RAND_CYCLES = 300;
   // directed part takes about 800 cycles and each random round about 400.
   localparam int STIM_CYCLES = 800 + RAND_ROUNDS * 400;

   logic                                  ACLK;
   logic                                  ARESETN;
   logic [ADDR_WIDTH-1:0]                 AWADDR;
   logic [ADDR_WIDTH-1:0]                 ARADDR;
   logic [DATA_WIDTH-1:0]                 WDATA;
   logic [DATA_WIDTH-1:0]                 RDATA;
   logic [DATA_WIDTH/8-1:0]               WSTRB;
   logic [1:0]                            BRESP;
   logic [1:0]                            RRESP;
   logic AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
   logic ARVALID, ARREADY, RVALID, RREADY;
   logic                                  in_valid;
   logic [WORD_WIDTH-1:0]                 in_data;
   logic [NUM_QUEUES-1:0]                 pop;
   logic [NUM_QUEUES-1:0][WORD_WIDTH-1:0] out_data;
   logic [NUM_QUEUES-1:0]                 empty;
   logic [NUM_QUEUES-1:0]                 full;
   logic [2:0]                            exp_tgt;
   int                                    data_errs;
   int                                    reg_errs;
   int                                    flag_errs;
   bit                                    timed_out;
   int                                    sh_qnum;
   int                                    sh_ratio [NUM_QUEUES];
   int                                    sched_cur;
   int                                    sched_run;

   output_queues #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .WORD_WIDTH (WORD_WIDTH),
      .DEPTH_LOG2 (DEPTH_LOG2)
   ) output_queues_i (.*);

   oq_checker #(
      .WORD_WIDTH (WORD_WIDTH),
      .DEPTH_LOG2 (DEPTH_LOG2),
      .MAX_CYCLES (2 * STIM_CYCLES)
   ) oq_checker_i (.*);

   initial begin
      ACLK = 1'b0;
      forever #20 ACLK = ~ACLK;
   end

   // split rule on the modelled schedule.
   function automatic int expected_queue(input int cur, input int run,
                                         output int next_cur, output int next_run);
      int active;
      int tgt;
      int base;
      int ratio;
      active = (sh_qnum < 1) ? 1 : (sh_qnum > NUM_QUEUES) ? NUM_QUEUES : sh_qnum;
      tgt    = (cur < active) ? cur : 0;
      base   = (cur < active) ? run : 0;
      ratio  = (sh_ratio[tgt] == 0) ? 1 : sh_ratio[tgt];
      next_cur = tgt;
      next_run = base + 1;
      if (base + 1 >= ratio) begin
         next_cur = (tgt + 1 < active) ? tgt + 1 : 0;
         next_run = 0;
      end
      return tgt;
   endfunction

   task automatic drive_cycle(input logic valid, input logic [NUM_QUEUES-1:0] pops);
      int nc;
      int nr;
      @(posedge ACLK);
      #2;
      in_valid = valid;
      pop      = pops;
      if (valid) begin
         in_data   = {$urandom, $urandom};
         exp_tgt   = 3'(expected_queue(sched_cur, sched_run, nc, nr));
         sched_cur = nc;
         sched_run = nr;
      end
   endtask

   task automatic send_words(input int n);
      repeat (n) drive_cycle(1'b1, '0);
      drive_cycle(1'b0, '0);
   endtask

   task automatic drain_queues();
      while (empty != '1)
         drive_cycle(1'b0, ~empty);
      drive_cycle(1'b0, '0);
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge ACLK);
      #2;
      AWADDR  = ADDR_WIDTH'(addr);
      AWVALID = 1'b1;
      while (!AWREADY) begin
         @(posedge ACLK);
         #2;
      end
      @(posedge ACLK);
      #2;
      AWVALID = 1'b0;
      WDATA   = data;
      WVALID  = 1'b1;
      while (!WREADY) begin
         @(posedge ACLK);
         #2;
      end
      @(posedge ACLK);
      #2;
      WVALID = 1'b0;
      repeat ($urandom_range(0, 2)) begin   // slow BREADY.
         @(posedge ACLK);
         #2;
      end
      BREADY = 1'b1;
      while (!BVALID) begin
         @(posedge ACLK);
         #2;
      end
      @(posedge ACLK);
      #2;
      BREADY = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr);
      @(posedge ACLK);
      #2;
      ARADDR  = ADDR_WIDTH'(addr);
      ARVALID = 1'b1;
      while (!ARREADY) begin
         @(posedge ACLK);
         #2;
      end
      @(posedge ACLK);
      #2;
      ARVALID = 1'b0;
      repeat ($urandom_range(0, 2)) begin
         @(posedge ACLK);
         #2;
      end
      RREADY = 1'b1;
      while (!RVALID) begin
         @(posedge ACLK);
         #2;
      end
      @(posedge ACLK);
      #2;
      RREADY = 1'b0;
   endtask

   task automatic set_reg(input logic [7:0] addr, input logic [31:0] data);
      axi_write(addr, data);
      if (addr == QUEUES_NUM)
         sh_qnum = int'(data);
      else if (addr >= SPLIT_RATIO_0 && addr <= SPLIT_RATIO_4)
         sh_ratio[addr[2:0]] = int'(data);
   endtask

   task automatic read_all_regs();
      axi_read(QUEUES_NUM);
      axi_read(RESET_DROP_COUNTS);
      for (int i = 0; i < NUM_QUEUES; i++) begin
         axi_read(8'(DROP_COUNT_0) + 8'(i));
         axi_read(8'(SPLIT_RATIO_0) + 8'(i));
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d data, %0d register, %0d flag, timeout %0d",
               data_errs, reg_errs, flag_errs, timed_out);
      if (timed_out || data_errs + reg_errs + flag_errs != 0)
         $display("Simulation failed");
      else
         $display("Simulation completed successfully");
      $finish;
   endtask

   initial begin
      wait (timed_out);
      finish_run();
   end

   initial begin
      void'($urandom(78));
      {AWADDR, AWVALID, WDATA, WVALID, BREADY, ARADDR, ARVALID, RREADY} = '0;
      WSTRB     = '1;
      in_valid  = 1'b0;
      in_data   = '0;
      pop       = '0;
      exp_tgt   = '0;
      sh_qnum   = 0;
      sh_ratio  = '{default: 0};
      sched_cur = 0;
      sched_run = 0;
      ARESETN   = 1'b0;
      repeat (16) @(posedge ACLK);
      #2;
      ARESETN = 1'b1;
      read_all_regs();
      set_reg(QUEUES_NUM, 32'd3);
      set_reg(SPLIT_RATIO_0, 32'd2);
      set_reg(SPLIT_RATIO_1, 32'd1);
      set_reg(SPLIT_RATIO_2, 32'd3);
      read_all_regs();
      axi_read(8'h30);
      axi_write(8'h30, 32'hdead_beef);
      axi_write(DROP_COUNT_2, 32'd7);
      send_words(12);
      drain_queues();
      // two queues fill up with nobody popping.
      set_reg(QUEUES_NUM, 32'd2);
      set_reg(SPLIT_RATIO_0, 32'd1);
      send_words(21);
      read_all_regs();
      set_reg(RESET_DROP_COUNTS, 32'd1);
      send_words(3);
      read_all_regs();
      set_reg(RESET_DROP_COUNTS, 32'd0);
      send_words(4);
      read_all_regs();
      drain_queues();
      for (int r = 0; r < RAND_ROUNDS; r++) begin
         set_reg(QUEUES_NUM, $urandom_range(0, 6));   // 0 and 6 hit the clamp.
         for (int q = 0; q < NUM_QUEUES; q++)
            set_reg(8'(SPLIT_RATIO_0) + 8'(q), $urandom_range(0, 3));
         repeat (RAND_CYCLES)
            drive_cycle(1'($urandom_range(0, 1)), NUM_QUEUES'($urandom & $urandom));
         drive_cycle(1'b0, '0);
         read_all_regs();
      end
      drain_queues();
      read_all_regs();
      finish_run();
   end

endmodule

`default_nettype wire

/* test/oq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module oq_checker #(
   parameter int WORD_WIDTH = 64,
   parameter int DEPTH_LOG2 = 3,
   parameter int MAX_CYCLES = 4000
) (
   input  wire                                          ACLK,
   input  wire                                          ARESETN,
   input  wire [31:0]                                   AWADDR,
   input  wire [31:0]                                   WDATA,
   input  wire [31:0]                                   ARADDR,
   input  wire [31:0]                                   RDATA,
   input  wire [1:0]                                    BRESP,
   input  wire [1:0]                                    RRESP,
   input  wire AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY,
   input  wire ARVALID, ARREADY, RVALID, RREADY,
   input  wire                                          in_valid,
   input  wire [WORD_WIDTH-1:0]                         in_data,
   input  wire [2:0]                                    exp_tgt,
   input  wire [oq_pkg::NUM_QUEUES-1:0]                 pop,
   input  wire [oq_pkg::NUM_QUEUES-1:0][WORD_WIDTH-1:0] out_data,
   input  wire [oq_pkg::NUM_QUEUES-1:0]                 empty,
   input  wire [oq_pkg::NUM_QUEUES-1:0]                 full,
   output int                                           data_errs,
   output int                                           reg_errs,
   output int                                           flag_errs,
   output bit                                           timed_out
);
   import oq_pkg::*;
   import oq_regs_pkg::*;

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   logic [WORD_WIDTH-1:0] model_q [NUM_QUEUES][$];
   logic [31:0]           drops [NUM_QUEUES];
   logic [31:0]           m_ratio [NUM_QUEUES];
   logic [31:0]           m_qnum;
   logic                  m_clr;
   logic [7:0]            aw_addr;
   logic [7:0]            ar_addr;
   logic [1:0]            exp_bresp;
   logic [33:0]           exp_read;
   logic                  was_full;
   int                    cycles;

   always @(posedge ACLK) begin
      if (!ARESETN) begin
         for (int i = 0; i < NUM_QUEUES; i++) begin
            model_q[i].delete();
            drops[i]   = '0;
            m_ratio[i] = '0;
         end
         m_qnum    = '0;
         m_clr     = 1'b0;
         exp_bresp = RESP_OKAY;
      end else begin
         // responses see the model as it stood before this edge.
         if (RVALID && RREADY) begin
            case (ar_addr)
               QUEUES_NUM:        exp_read = {RESP_OKAY, m_qnum};
               RESET_DROP_COUNTS: exp_read = {RESP_OKAY, 31'd0, m_clr};
               DROP_COUNT_0, DROP_COUNT_1, DROP_COUNT_2, DROP_COUNT_3, DROP_COUNT_4:
                  exp_read = {RESP_OKAY, drops[ar_addr[2:0]]};
               SPLIT_RATIO_0, SPLIT_RATIO_1, SPLIT_RATIO_2, SPLIT_RATIO_3, SPLIT_RATIO_4:
                  exp_read = {RESP_OKAY, m_ratio[ar_addr[2:0]]};
               default:           exp_read = {RESP_SLVERR, 32'd0};
            endcase
            if ({RRESP, RDATA} !== exp_read) begin
               reg_errs++;
               $display("CHECK FAILED @%0t: read 0x%h gave resp %0d data 0x%h, expected %0d 0x%h",
                        $time, ar_addr, RRESP, RDATA, exp_read[33:32], exp_read[31:0]);
            end
         end
         if (BVALID && BREADY && BRESP !== exp_bresp) begin
            reg_errs++;
            $display("CHECK FAILED @%0t: write 0x%h gave resp %0d, expected %0d",
                     $time, aw_addr, BRESP, exp_bresp);
         end
         was_full = model_q[exp_tgt].size() == DEPTH;   // full is tested before the pop.
         for (int i = 0; i < NUM_QUEUES; i++) begin
            if (empty[i] !== (model_q[i].size() == 0) ||
                full[i] !== (model_q[i].size() == DEPTH)) begin
               flag_errs++;
               $display("CHECK FAILED @%0t: queue %0d empty %b full %b, model holds %0d words",
                        $time, i, empty[i], full[i], model_q[i].size());
            end
            if (pop[i] && model_q[i].size() != 0) begin
               if (out_data[i] !== model_q[i][0]) begin
                  data_errs++;
                  $display("CHECK FAILED @%0t: queue %0d popped 0x%h, expected 0x%h",
                           $time, i, out_data[i], model_q[i][0]);
               end
               void'(model_q[i].pop_front());
            end
         end
         if (in_valid) begin
            if (!was_full)
               model_q[exp_tgt].push_back(in_data);
            else if (!m_clr)
               drops[exp_tgt]++;
         end
         if (m_clr)
            drops = '{default: '0};
         if (ARVALID && ARREADY)
            ar_addr = ARADDR[7:0];
         if (AWVALID && AWREADY)
            aw_addr = AWADDR[7:0];
         if (WVALID && WREADY) begin
            exp_bresp = RESP_OKAY;
            case (aw_addr)
               QUEUES_NUM:        m_qnum = WDATA;
               RESET_DROP_COUNTS: m_clr = WDATA[0];
               SPLIT_RATIO_0, SPLIT_RATIO_1, SPLIT_RATIO_2, SPLIT_RATIO_3, SPLIT_RATIO_4:
                  m_ratio[aw_addr[2:0]] = WDATA;
               default:           exp_bresp = RESP_SLVERR;   // drop counts included.
            endcase
         end
      end
   end

   always @(posedge ACLK) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
         timed_out <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* src/output_queues.sv */
`timescale 1ns/1ps
`default_nettype none

module output_queues #(
   parameter int DATA_WIDTH = 32,
   parameter int ADDR_WIDTH = 32,
   parameter int WORD_WIDTH = 64,
   parameter int DEPTH_LOG2 = 3
) (
   input  wire                                         ACLK,
   input  wire                                         ARESETN,
   input  wire [ADDR_WIDTH-1:0]                        AWADDR,
   input  wire                                         AWVALID,
   output wire                                         AWREADY,
   input  wire [DATA_WIDTH-1:0]                        WDATA,
   input  wire [DATA_WIDTH/8-1:0]                      WSTRB,
   input  wire                                         WVALID,
   output wire                                         WREADY,
   output wire [1:0]                                   BRESP,
   output wire                                         BVALID,
   input  wire                                         BREADY,
   input  wire [ADDR_WIDTH-1:0]                        ARADDR,
   input  wire                                         ARVALID,
   output wire                                         ARREADY,
   output wire [DATA_WIDTH-1:0]                        RDATA,
   output wire [1:0]                                   RRESP,
   output wire                                         RVALID,
   input  wire                                         RREADY,
   input  wire                                         in_valid,
   input  wire [WORD_WIDTH-1:0]                        in_data,
   input  wire [oq_pkg::NUM_QUEUES-1:0]                pop,
   output wire [oq_pkg::NUM_QUEUES-1:0][WORD_WIDTH-1:0] out_data,
   output wire [oq_pkg::NUM_QUEUES-1:0]                empty,
   output wire [oq_pkg::NUM_QUEUES-1:0]                full
);
   import oq_pkg::*;

   oq_cfg_t                 cfg;
   oq_stats_t               stats;
   logic [NUM_QUEUES-1:0]   push;
   logic [WORD_WIDTH-1:0]   push_data;

   output_queues_regs #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH)
   ) regs_i (
      .ACLK    (ACLK),
      .ARESETN (ARESETN),
      .cfg     (cfg),
      .stats   (stats),
      .AWADDR  (AWADDR),
      .AWVALID (AWVALID),
      .AWREADY (AWREADY),
      .WDATA   (WDATA),
      .WSTRB   (WSTRB),
      .WVALID  (WVALID),
      .WREADY  (WREADY),
      .BRESP   (BRESP),
      .BVALID  (BVALID),
      .BREADY  (BREADY),
      .ARADDR  (ARADDR),
      .ARVALID (ARVALID),
      .ARREADY (ARREADY),
      .RDATA   (RDATA),
      .RRESP   (RRESP),
      .RVALID  (RVALID),
      .RREADY  (RREADY)
   );

   oq_dispatch #(
      .WORD_WIDTH (WORD_WIDTH)
   ) dispatch_i (
      .ACLK      (ACLK),
      .ARESETN   (ARESETN),
      .cfg       (cfg),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .full      (full),
      .push      (push),
      .push_data (push_data),
      .stats     (stats)
   );

   // one FIFO per output queue, sharing the push word.
   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
      oq_fifo #(
         .WORD_WIDTH (WORD_WIDTH),
         .DEPTH_LOG2 (DEPTH_LOG2)
      ) fifo_i (
         .ACLK      (ACLK),
         .ARESETN   (ARESETN),
         .push      (push[i]),
         .push_data (push_data),
         .pop       (pop[i]),
         .head_data (out_data[i]),
         .empty     (empty[i]),
         .full      (full[i])
      );
   end

endmodule

`default_nettype wire

/* src/oq_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module oq_fifo #(
   parameter int WORD_WIDTH = 64,
   parameter int DEPTH_LOG2 = 3
) (
   input  wire                     ACLK,
   input  wire                     ARESETN,
   input  wire                     push,
   input  wire [WORD_WIDTH-1:0]    push_data,
   input  wire                     pop,
   output logic [WORD_WIDTH-1:0]   head_data,
   output logic                    empty,
   output logic                    full
);
   localparam int DEPTH = 2 ** DEPTH_LOG2;

   logic [WORD_WIDTH-1:0]  mem [DEPTH];
   logic [DEPTH_LOG2:0]    wr_ptr;
   logic [DEPTH_LOG2:0]    rd_ptr;
   logic                   do_push;
   logic                   do_pop;

   // extra pointer bit tells full from empty.
   assign empty = wr_ptr == rd_ptr;
   assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                  (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

   assign do_push   = push & ~full;
   assign do_pop    = pop & ~empty;   // pop of an empty queue is ignored.
   assign head_data = empty ? '0 : mem[rd_ptr[DEPTH_LOG2-1:0]];

   always_ff @(posedge ACLK) begin
      if (do_push)
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= push_data;
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* src/oq_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module oq_dispatch #(
   parameter int WORD_WIDTH = 64
) (
   input  wire                              ACLK,
   input  wire                              ARESETN,
   input  wire oq_pkg::oq_cfg_t             cfg,
   input  wire                              in_valid,
   input  wire [WORD_WIDTH-1:0]             in_data,
   input  wire [oq_pkg::NUM_QUEUES-1:0]     full,
   output logic [oq_pkg::NUM_QUEUES-1:0]    push,
   output logic [WORD_WIDTH-1:0]            push_data,
   output oq_pkg::oq_stats_t                stats
);
   import oq_pkg::*;

   // wide enough for an index and for the active count.
   localparam int QW = $clog2(NUM_QUEUES + 1);

   logic [QW-1:0]  cur_q;
   logic [31:0]    run_cnt;
   logic [QW-1:0]  active;
   logic           in_run;
   logic [QW-1:0]  tgt;
   logic [QW-1:0]  tgt_inc;
   logic [31:0]    ratio;
   logic [31:0]    run_inc;
   logic           drop;

   // clamp queues_num to 1..NUM_QUEUES.
   always_comb begin
      if (cfg.queues_num == '0)
         active = QW'(1);
      else if (cfg.queues_num > 32'(NUM_QUEUES))
         active = QW'(NUM_QUEUES);
      else
         active = cfg.queues_num[QW-1:0];
   end

   assign in_run  = cur_q < active;
   assign tgt     = in_run ? cur_q : '0;   // out of range restarts at 0.
   assign tgt_inc = tgt + QW'(1);
   assign ratio   = (cfg.split_ratio[tgt] == '0) ? 32'd1 : cfg.split_ratio[tgt];
   assign run_inc = (in_run ? run_cnt : 32'd0) + 32'd1;
   assign drop    = in_valid & full[tgt];

   always_comb begin
      push      = '0;
      push[tgt] = in_valid & ~full[tgt];
   end

   assign push_data = in_data;

   // dropped words still move the schedule.
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         cur_q   <= '0;
         run_cnt <= '0;
      end else if (in_valid) begin
         if (run_inc >= ratio) begin
            cur_q   <= (tgt_inc >= active) ? '0 : tgt_inc;
            run_cnt <= '0;
         end else begin
            cur_q   <= tgt;
            run_cnt <= run_inc;
         end
      end
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN || cfg.reset_drop_counts)
         stats <= '0;   // held at zero while clear is set.
      else if (drop)
         stats.drop_count[tgt] <= stats.drop_count[tgt] + 32'd1;
   end

endmodule

`default_nettype wire

/* src/output_queues_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module output_queues_regs #(
   parameter int DATA_WIDTH = 32,
   parameter int ADDR_WIDTH = 32
) (
   input  wire                       ACLK,
   input  wire                       ARESETN,
   output oq_pkg::oq_cfg_t           cfg,
   input  wire oq_pkg::oq_stats_t    stats,
   input  wire [ADDR_WIDTH-1:0]      AWADDR,
   input  wire                       AWVALID,
   output logic                      AWREADY,
   input  wire [DATA_WIDTH-1:0]      WDATA,
   input  wire [DATA_WIDTH/8-1:0]    WSTRB,
   input  wire                       WVALID,
   output logic                      WREADY,
   output logic [1:0]                BRESP,
   output logic                      BVALID,
   input  wire                       BREADY,
   input  wire [ADDR_WIDTH-1:0]      ARADDR,
   input  wire                       ARVALID,
   output logic                      ARREADY,
   output logic [DATA_WIDTH-1:0]     RDATA,
   output logic [1:0]                RRESP,
   output logic                      RVALID,
   input  wire                       RREADY
);
   import oq_pkg::*;
   import oq_regs_pkg::*;

   oq_wr_state_e  wr_state;
   oq_wr_state_e  wr_state_next;
   oq_rd_state_e  rd_state;
   oq_rd_state_e  rd_state_next;
   logic [7:0]    wr_addr;
   logic [7:0]    wr_addr_next;
   logic [7:0]    rd_addr;
   logic [7:0]    rd_addr_next;
   axi_resp_e     bresp_q;
   axi_resp_e     bresp_next;
   oq_cfg_t       cfg_next;

   assign BRESP = bresp_q;

   // read channel.
   always_comb begin
      rd_state_next = rd_state;
      rd_addr_next  = rd_addr;
      ARREADY       = 1'b0;
      RVALID        = 1'b0;
      RDATA         = '0;
      RRESP         = RESP_OKAY;
      case (rd_state)
         RD_IDLE: begin
            ARREADY = 1'b1;
            if (ARVALID) begin
               rd_addr_next  = ARADDR[7:0];
               rd_state_next = RD_RESP;
            end
         end
         RD_RESP: begin
            RVALID = 1'b1;
            case (rd_addr)
               QUEUES_NUM:        RDATA = cfg.queues_num;
               RESET_DROP_COUNTS: RDATA = DATA_WIDTH'(cfg.reset_drop_counts);
               DROP_COUNT_0, DROP_COUNT_1, DROP_COUNT_2, DROP_COUNT_3, DROP_COUNT_4:
                  RDATA = stats.drop_count[rd_addr[2:0]];
               SPLIT_RATIO_0, SPLIT_RATIO_1, SPLIT_RATIO_2, SPLIT_RATIO_3, SPLIT_RATIO_4:
                  RDATA = cfg.split_ratio[rd_addr[2:0]];
               default:           RRESP = RESP_SLVERR;
            endcase
            if (RREADY)
               rd_state_next = RD_IDLE;
         end
      endcase
   end

   // write channel where drop counts are read only.
   always_comb begin
      wr_state_next = wr_state;
      wr_addr_next  = wr_addr;
      bresp_next    = bresp_q;
      cfg_next      = cfg;
      AWREADY       = 1'b0;
      WREADY        = 1'b0;
      BVALID        = 1'b0;
      case (wr_state)
         WR_IDLE: begin
            AWREADY = 1'b1;
            if (AWVALID) begin
               wr_addr_next  = AWADDR[7:0];
               wr_state_next = WR_DATA;
            end
         end
         WR_DATA: begin
            WREADY = 1'b1;
            if (WVALID) begin
               bresp_next = RESP_OKAY;
               case (wr_addr)
                  QUEUES_NUM:        cfg_next.queues_num = WDATA;
                  RESET_DROP_COUNTS: cfg_next.reset_drop_counts = WDATA[0];
                  SPLIT_RATIO_0, SPLIT_RATIO_1, SPLIT_RATIO_2, SPLIT_RATIO_3, SPLIT_RATIO_4:
                     cfg_next.split_ratio[wr_addr[2:0]] = WDATA;
                  default:           bresp_next = RESP_SLVERR;
               endcase
               wr_state_next = WR_RESP;
            end
         end
         WR_RESP: begin
            BVALID = 1'b1;
            if (BREADY)
               wr_state_next = WR_IDLE;
         end
         default: wr_state_next = WR_IDLE;
      endcase
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_state <= WR_IDLE;
         rd_state <= RD_IDLE;
         bresp_q  <= RESP_OKAY;
         cfg      <= '0;
      end else begin
         wr_state <= wr_state_next;
         rd_state <= rd_state_next;
         bresp_q  <= bresp_next;
         cfg      <= cfg_next;
      end
   end

   always_ff @(posedge ACLK) begin
      wr_addr <= wr_addr_next;
      rd_addr <= rd_addr_next;
   end

endmodule

`default_nettype wire

/* src/oq_regs_pkg.sv */
`default_nettype none

package oq_regs_pkg;

   // low address byte of each register.
   typedef enum logic [7:0] {
      QUEUES_NUM        = 8'h00,
      RESET_DROP_COUNTS = 8'h01,
      DROP_COUNT_0      = 8'h10,
      DROP_COUNT_1      = 8'h11,
      DROP_COUNT_2      = 8'h12,
      DROP_COUNT_3      = 8'h13,
      DROP_COUNT_4      = 8'h14,
      SPLIT_RATIO_0     = 8'h20,
      SPLIT_RATIO_1     = 8'h21,
      SPLIT_RATIO_2     = 8'h22,
      SPLIT_RATIO_3     = 8'h23,
      SPLIT_RATIO_4     = 8'h24
   } oq_reg_addr_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } oq_wr_state_e;

   typedef enum logic {
      RD_IDLE,
      RD_RESP
   } oq_rd_state_e;

endpackage

`default_nettype wire

/* src/oq_pkg.sv */
`default_nettype none

package oq_pkg;

   // five slots, fixed by the register map.
   localparam int NUM_QUEUES = 5;

   typedef logic [31:0] cfg_word_t;

   typedef struct packed {
      cfg_word_t                   queues_num;
      logic                        reset_drop_counts;
      cfg_word_t [NUM_QUEUES-1:0]  split_ratio;
   } oq_cfg_t;

   // per-queue drop totals.
   typedef struct packed {
      cfg_word_t [NUM_QUEUES-1:0]  drop_count;
   } oq_stats_t;

endpackage

`default_nettype wire
